// ==== src/isaPkg.sv ====
// Instruction formats, ALU functions and PSR flag layout of the 16-bit execute unit
// Imported by the decoder, the ALU, the register state and the top level

package isaPkg;

	// Register values and operands
	typedef logic [15:0] dataWord;

	// Top field of an instruction, zero selects the register class
	typedef enum logic [3:0] {
		majReg = 4'd0,
		majAddi, majAddui, majAddci, majAddcui,
		majSubi, majCmpi, majCmpui,
		majAndi, majOri, majXori,
		majMovi, majLshi, majRshi, majArshi
	} majorOp;

	// Extension field of the register class
	typedef enum logic [3:0] {
		extAdd = 4'd0,
		extAddu, extAddc, extAddcu,
		extSub, extCmp, extCmpu,
		extAnd, extOr, extXor, extNot,
		extLsh, extRsh, extMov, extNop
	} opExt;

	// Rdest op Rsrc
	typedef struct packed {
		majorOp op;
		logic [3:0] rDest;
		opExt ext;
		logic [3:0] rSrc;
	} regForm;

	// Rdest op imm8
	typedef struct packed {
		majorOp op;
		logic [3:0] rDest;
		logic [7:0] imm8;
	} immForm;

	// Same 16 bits, read by the major field
	typedef union packed {
		regForm rForm;
		immForm iForm;
	} instrWord;

	// Functions the ALU can perform
	typedef enum logic [4:0] {
		aluAdd = 5'd0,
		aluAddc, aluSub, aluCmp, aluCmpu,
		aluAnd, aluOr, aluXor, aluNot,
		aluLsh, aluRsh, aluArsh,
		aluPassB, aluZero
	} aluOp;

	// PSR bit order, n is bit 4 and c is bit 0
	// Also serves as a per-flag update mask
	typedef struct packed {
		logic n;
		logic z;
		logic f;
		logic l;
		logic c;
	} psrFlags;

endpackage

// ==== src/busPkg.sv ====
// AXI4-Lite channel bundles, response codes and register map offsets
// Shared by the bus slave, the top level and the testbench

package busPkg;

	// Everything the host drives
	typedef struct packed {
		logic [7:0] awaddr;
		logic awvalid;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic wvalid;
		logic bready;
		logic [7:0] araddr;
		logic arvalid;
		logic rready;
	} axiLiteReq;

	// Everything the slave drives
	typedef struct packed {
		logic awready;
		logic wready;
		logic [1:0] bresp;
		logic bvalid;
		logic arready;
		logic [31:0] rdata;
		logic [1:0] rresp;
		logic rvalid;
	} axiLiteRsp;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// Fixed offsets, general registers sit in a separate window
	localparam logic [7:0] instrOffset = 8'h00;
	localparam logic [7:0] psrOffset = 8'h04;

endpackage

// ==== src/alu.sv ====
// Combinational 16-bit ALU, gives the result and every candidate flag
// The decoder picks which flags reach the PSR

`timescale 1ns/10ps

module alu import isaPkg::*; (
	input dataWord a,
	input dataWord b,
	input logic cin,
	input aluOp op,
	output dataWord result,
	output psrFlags flags
);

	logic addCin;
	logic [16:0] sum;
	logic [16:0] diff;
	logic [3:0] shAmt;
	logic bigShift;
	logic signed [15:0] arShift;

	// Carry in only for the carry forms
	assign addCin = (op == aluAddc) ? cin : 1'b0;
	assign sum = {1'b0, a} + {1'b0, b} + {16'b0, addCin};

	// Two's complement subtract, bit 16 is the inverted borrow
	assign diff = {1'b0, a} + {1'b0, ~b} + 17'd1;

	// Amount from the low five bits of b
	assign shAmt = b[3:0];
	assign bigShift = b[4];
	assign arShift = $signed(a) >>> shAmt;

	always_comb
	begin
		result = '0;
		flags = '0;
		case (op)
			aluAdd, aluAddc:
			begin
				result = sum[15:0];
				flags.c = sum[16];
				// Same operand signs, result sign flipped
				flags.f = (a[15] == b[15]) && (sum[15] != a[15]);
			end
			aluSub:
			begin
				result = diff[15:0];
				flags.c = diff[16];
				// Operand signs differ and result takes the sign of b
				flags.f = (a[15] != b[15]) && (diff[15] != a[15]);
			end
			aluCmp, aluCmpu:
			begin
				// No write-back, result stays zero
				flags.l = b > a;
				flags.n = $signed(b) > $signed(a);
			end
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluXor: result = a ^ b;
			aluNot: result = ~a;
			aluLsh: result = bigShift ? '0 : a << shAmt;
			aluRsh: result = bigShift ? '0 : a >> shAmt;
			aluArsh:
			begin
				// Sixteen or more leaves only sign bits
				if (bigShift)
					result = {16{a[15]}};
				else
					result = arShift;
			end
			aluPassB: result = b;
			default: result = '0;
		endcase
		// Compares flag equality, everything else a zero result
		if (op == aluCmp || op == aluCmpu)
			flags.z = (a == b);
		else
			flags.z = (result == '0);
	end

endmodule

// ==== src/instrDecode.sv ====
// Instruction decoder, maps one word to ALU function, operand source and PSR mask
// Purely combinational, driven from the bus slave

`timescale 1ns/10ps

module instrDecode import isaPkg::*; (
	input instrWord instr,
	output aluOp op,
	output logic useImm,
	output dataWord immVal,
	output logic wbEn,
	output psrFlags flagMask,
	output logic illegal
);

	localparam psrFlags maskZF = '{n: 1'b0, z: 1'b1, f: 1'b1, l: 1'b0, c: 1'b0};
	localparam psrFlags maskC = '{n: 1'b0, z: 1'b0, f: 1'b0, l: 1'b0, c: 1'b1};
	localparam psrFlags maskZL = '{n: 1'b0, z: 1'b1, f: 1'b0, l: 1'b1, c: 1'b0};
	localparam psrFlags maskZN = '{n: 1'b1, z: 1'b1, f: 1'b0, l: 1'b0, c: 1'b0};

	dataWord sImm;
	dataWord zImm;
	logic signImm;
	logic isUnsigned;

	assign sImm = {{8{instr.iForm.imm8[7]}}, instr.iForm.imm8};
	assign zImm = {8'h00, instr.iForm.imm8};

	// Signed immediates only for the signed arithmetic forms
	assign signImm = instr.iForm.op inside {majAddi, majAddci, majSubi, majCmpi};

	// Unsigned adds touch only the carry
	assign isUnsigned = (instr.rForm.op == majReg) ?
		(instr.rForm.ext inside {extAddu, extAddcu}) :
		(instr.iForm.op inside {majAddui, majAddcui});

	always_comb
	begin
		op = aluZero;
		useImm = 1'b0;
		immVal = signImm ? sImm : zImm;
		illegal = 1'b0;
		if (instr.rForm.op == majReg)
		begin
			case (instr.rForm.ext)
				extAdd, extAddu: op = aluAdd;
				extAddc, extAddcu: op = aluAddc;
				extSub: op = aluSub;
				extCmp: op = aluCmp;
				extCmpu: op = aluCmpu;
				extAnd: op = aluAnd;
				extOr: op = aluOr;
				extXor: op = aluXor;
				extNot: op = aluNot;
				extLsh: op = aluLsh;
				extRsh: op = aluRsh;
				extMov: op = aluPassB;
				extNop: op = aluZero;
				default: illegal = 1'b1;
			endcase
			// Register shifts move one place
			if (op == aluLsh || op == aluRsh)
			begin
				useImm = 1'b1;
				immVal = 16'd1;
			end
		end
		else
		begin
			useImm = 1'b1;
			case (instr.iForm.op)
				majAddi, majAddui: op = aluAdd;
				majAddci, majAddcui: op = aluAddc;
				majSubi: op = aluSub;
				majCmpi: op = aluCmp;
				majCmpui: op = aluCmpu;
				majAndi: op = aluAnd;
				majOri: op = aluOr;
				majXori: op = aluXor;
				majMovi: op = aluPassB;
				majLshi: op = aluLsh;
				majRshi: op = aluRsh;
				majArshi: op = aluArsh;
				default:
				begin
					illegal = 1'b1;
					useImm = 1'b0;
				end
			endcase
		end
		// Flags the instruction may change
		case (op)
			aluAdd, aluAddc: flagMask = isUnsigned ? maskC : maskZF;
			aluSub: flagMask = maskZF;
			aluCmp: flagMask = maskZN;
			aluCmpu: flagMask = maskZL;
			default: flagMask = '0;
		endcase
		// Compares, NOP and illegal words leave Rdest alone
		wbEn = !(op inside {aluCmp, aluCmpu, aluZero});
	end

endmodule

// ==== src/archState.sv ====
// General registers and PSR, written by instruction commit or host load
// Reads are combinational for the ALU operands and the host port

`timescale 1ns/10ps

module archState import isaPkg::*; (
	input logic clk,
	input logic rstN,
	input logic exec,
	input logic wbEn,
	input psrFlags flagMask,
	input logic [3:0] rDestIdx,
	input logic [3:0] rSrcIdx,
	input dataWord result,
	input psrFlags flags,
	input logic hostWe,
	input logic [3:0] hostIdx,
	input dataWord hostData,
	input logic [3:0] hostRdIdx,
	output dataWord opA,
	output dataWord opB,
	output dataWord rdData,
	output psrFlags psr,
	output logic cin
);

	dataWord regs [16];

	assign opA = regs[rDestIdx];
	assign opB = regs[rSrcIdx];
	assign rdData = regs[hostRdIdx];
	assign cin = psr.c;

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			regs <= '{default: '0};
			psr <= '0;
		end
		else
		begin
			// Host load and commit never land on the same edge
			if (hostWe)
				regs[hostIdx] <= hostData;
			else if (exec && wbEn)
				regs[rDestIdx] <= result;
			// Masked flags update, the rest hold
			if (exec)
				psr <= (psr & ~flagMask) | (flags & flagMask);
		end
	end

endmodule

// ==== src/axiLiteSlave.sv ====
// AXI4-Lite slave for the execute unit, one write or read in flight per channel
// Instruction writes trigger execution, register window writes load registers

`timescale 1ns/10ps

module axiLiteSlave import isaPkg::*, busPkg::*; #(
	parameter logic [7:0] regBase = 8'h40
) (
	input logic clk,
	input logic rstN,
	input axiLiteReq axiReq,
	output axiLiteRsp axiRsp,
	input logic illegal,
	input dataWord rdData,
	input psrFlags psr,
	output instrWord instr,
	output logic exec,
	output logic hostWe,
	output logic [3:0] hostIdx,
	output dataWord hostData,
	output logic [3:0] hostRdIdx
);

	logic wrReady;
	logic bValid;
	logic [1:0] bResp;
	logic arReady;
	logic rValid;
	logic [31:0] rData;
	logic [1:0] rResp;
	logic [7:0] wrAddr;
	dataWord wrData;
	logic strbOk;
	logic [7:0] rdAddr;
	logic wrStart;
	logic wrHs;
	logic rdStart;
	logic rdHs;
	logic wrIsInstr;
	logic wrIsReg;

	// Register n at regBase + 4n, word aligned
	function automatic logic inRegWindow(input logic [7:0] addr);
		logic [7:0] offset;
		offset = addr - regBase;
		return (addr >= regBase) && (offset[7:6] == 2'b00) && (offset[1:0] == 2'b00);
	endfunction

	function automatic logic [3:0] regIndex(input logic [7:0] addr);
		logic [7:0] offset;
		offset = addr - regBase;
		return offset[5:2];
	endfunction

	// Address and data seen together, no response pending
	assign wrStart = axiReq.awvalid && axiReq.wvalid && !bValid && !wrReady;
	assign wrHs = wrReady && axiReq.awvalid && axiReq.wvalid;
	assign rdStart = axiReq.arvalid && !rValid && !arReady;
	assign rdHs = arReady && axiReq.arvalid;

	assign wrIsInstr = (wrAddr == instrOffset);
	assign wrIsReg = inRegWindow(wrAddr);

	// Datapath strobes fire on the completing edge
	assign instr = wrData;
	assign exec = wrHs && wrIsInstr && strbOk && !illegal;
	assign hostWe = wrHs && wrIsReg && strbOk;
	assign hostIdx = regIndex(wrAddr);
	assign hostData = wrData;
	assign hostRdIdx = regIndex(rdAddr);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			wrReady <= 1'b0;
			bValid <= 1'b0;
			arReady <= 1'b0;
			rValid <= 1'b0;
		end
		else
		begin
			// Ready pulses for a single cycle
			wrReady <= wrStart;
			arReady <= rdStart;
			// Response held until the host takes it
			if (wrHs)
				bValid <= 1'b1;
			else if (axiReq.bready)
				bValid <= 1'b0;
			if (rdHs)
				rValid <= 1'b1;
			else if (axiReq.rready)
				rValid <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrStart)
		begin
			wrAddr <= axiReq.awaddr;
			wrData <= axiReq.wdata[15:0];
			strbOk <= &axiReq.wstrb[1:0];
		end
		// PSR is read-only, any write there fails
		if (wrHs)
			bResp <= (strbOk && (wrIsReg || (wrIsInstr && !illegal))) ? respOkay : respSlvErr;
		if (rdStart)
			rdAddr <= axiReq.araddr;
		// Values sampled before any commit on this edge
		if (rdHs)
		begin
			if (rdAddr == psrOffset)
			begin
				rData <= {27'b0, psr};
				rResp <= respOkay;
			end
			else if (inRegWindow(rdAddr))
			begin
				rData <= {16'b0, rdData};
				rResp <= respOkay;
			end
			else
			begin
				rData <= '0;
				rResp <= respSlvErr;
			end
		end
	end

	assign axiRsp = '{
		awready: wrReady,
		wready: wrReady,
		bresp: bResp,
		bvalid: bValid,
		arready: arReady,
		rdata: rData,
		rresp: rResp,
		rvalid: rValid
	};

endmodule

// ==== src/aluCore.sv ====
// Top level of the execute unit, AXI4-Lite in, one instruction per write
// Connects bus slave, decoder, ALU and register state

`timescale 1ns/10ps

module aluCore import isaPkg::*, busPkg::*; #(
	parameter logic [7:0] regBase = 8'h40
) (
	input logic clk,
	input logic rstN,
	input axiLiteReq axiReq,
	output axiLiteRsp axiRsp
);

	instrWord instr;
	logic exec;
	logic hostWe;
	logic [3:0] hostIdx;
	logic [3:0] hostRdIdx;
	dataWord hostData;
	dataWord rdData;
	dataWord opA;
	dataWord opB;
	dataWord immVal;
	dataWord result;
	psrFlags psr;
	psrFlags flags;
	psrFlags flagMask;
	aluOp op;
	logic useImm;
	logic wbEn;
	logic illegal;
	logic cin;

	axiLiteSlave #(
		.regBase(regBase)
	) i_slave (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiRsp(axiRsp),
		.illegal(illegal),
		.rdData(rdData),
		.psr(psr),
		.instr(instr),
		.exec(exec),
		.hostWe(hostWe),
		.hostIdx(hostIdx),
		.hostData(hostData),
		.hostRdIdx(hostRdIdx)
	);

	instrDecode i_decode (
		.instr(instr),
		.op(op),
		.useImm(useImm),
		.immVal(immVal),
		.wbEn(wbEn),
		.flagMask(flagMask),
		.illegal(illegal)
	);

	// Operand B from Rsrc or the extended immediate
	alu i_alu (
		.a(opA),
		.b(useImm ? immVal : opB),
		.cin(cin),
		.op(op),
		.result(result),
		.flags(flags)
	);

	// Both forms keep Rdest in the same bits
	archState i_state (
		.clk(clk),
		.rstN(rstN),
		.exec(exec),
		.wbEn(wbEn),
		.flagMask(flagMask),
		.rDestIdx(instr.rForm.rDest),
		.rSrcIdx(instr.rForm.rSrc),
		.result(result),
		.flags(flags),
		.hostWe(hostWe),
		.hostIdx(hostIdx),
		.hostData(hostData),
		.hostRdIdx(hostRdIdx),
		.opA(opA),
		.opB(opB),
		.rdData(rdData),
		.psr(psr),
		.cin(cin)
	);

endmodule

// ==== bench/aluCoreTb.sv ====
// Directed testbench for the execute unit, drives AXI4-Lite and checks against an ISA model
// Top module aluCoreTb, run through the file list with the Makefile

`timescale 1ns/10ps

module aluCoreTb import isaPkg::*, busPkg::*; ();

	localparam logic [7:0] regBase = 8'h40;
	// Roughly 960 bus transactions of four cycles each, plus margin
	localparam int cycleLimit = 6000;

	logic clk = 1'b0;
	logic rstN;
	axiLiteReq axiReq;
	axiLiteRsp axiRsp;

	// Reference copy of the architectural state
	dataWord refRegs [16];
	psrFlags refPsr;

	integer seed;
	int errCount;
	int cycleCount = 0;

	aluCore #(
		.regBase(regBase)
	) i_dut (
		.clk(clk),
		.rstN(rstN),
		.axiReq(axiReq),
		.axiRsp(axiRsp)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// Watchdog on total run length
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic compareValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		if (actVal !== expVal)
		begin
			$display("FAIL t=%0t %s expected=%h actual=%h", $time, name, expVal, actVal);
			errCount++;
		end
	endtask

	// Register n sits at regBase + 4n
	function automatic logic [7:0] regAddr(input logic [3:0] idx);
		return regBase + {2'b00, idx, 2'b00};
	endfunction

	function automatic logic [15:0] encReg(input opExt ext, input logic [3:0] rd,
		input logic [3:0] rs);
		return {4'd0, rd, ext, rs};
	endfunction

	function automatic logic [15:0] encImm(input majorOp maj, input logic [3:0] rd,
		input logic [7:0] imm);
		return {maj, rd, imm};
	endfunction

	// One write, address and data together, response checked
	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [1:0] expResp);
		@(posedge clk);
		axiReq.awaddr <= addr;
		axiReq.wdata <= data;
		axiReq.wstrb <= strb;
		axiReq.awvalid <= 1'b1;
		axiReq.wvalid <= 1'b1;
		axiReq.bready <= 1'b1;
		do @(posedge clk); while (!(axiRsp.awready && axiRsp.wready));
		axiReq.awvalid <= 1'b0;
		axiReq.wvalid <= 1'b0;
		do @(posedge clk); while (!axiRsp.bvalid);
		compareValue("bresp", {30'h0, expResp}, {30'h0, axiRsp.bresp});
	endtask

	task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		@(posedge clk);
		axiReq.araddr <= addr;
		axiReq.arvalid <= 1'b1;
		axiReq.rready <= 1'b1;
		do @(posedge clk); while (!axiRsp.arready);
		axiReq.arvalid <= 1'b0;
		do @(posedge clk); while (!axiRsp.rvalid);
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
	endtask

	task automatic loadReg(input logic [3:0] idx, input dataWord val);
		axiWrite(regAddr(idx), {16'h0, val}, 4'hF, respOkay);
		refRegs[idx] = val;
	endtask

	// ISA model for one instruction word
	task automatic refExec(input logic [15:0] w);
		logic [3:0] maj;
		logic [3:0] kind;
		logic [3:0] rd;
		dataWord a;
		dataWord b;
		dataWord res;
		logic [16:0] wide;
		logic cy;
		logic wb;
		psrFlags newF;
		psrFlags mask;
		maj = w[15:12];
		rd = w[11:8];
		a = refRegs[rd];
		res = '0;
		newF = '0;
		mask = '0;
		wb = 1'b1;
		// Operand B from Rsrc or the extended imm8
		if (maj == 4'd0)
			b = refRegs[w[3:0]];
		else if (maj inside {majAddi, majAddci, majSubi, majCmpi})
			b = {{8{w[7]}}, w[7:0]};
		else
			b = {8'h00, w[7:0]};
		// Register forms behave like the matching immediate op
		kind = maj;
		if (maj == 4'd0)
		begin
			case (w[7:4])
				extAdd: kind = majAddi;
				extAddu: kind = majAddui;
				extAddc: kind = majAddci;
				extAddcu: kind = majAddcui;
				extSub: kind = majSubi;
				extCmp: kind = majCmpi;
				extCmpu: kind = majCmpui;
				extAnd: kind = majAndi;
				extOr: kind = majOri;
				extXor: kind = majXori;
				extMov: kind = majMovi;
				extLsh:
				begin
					kind = majLshi;
					b = 16'd1;
				end
				extRsh:
				begin
					kind = majRshi;
					b = 16'd1;
				end
				// NOT keeps code zero, NOP falls to the default
				extNot: kind = 4'd0;
				default: kind = 4'hF;
			endcase
		end
		case (kind)
			majAddi, majAddui, majAddci, majAddcui:
			begin
				cy = (kind == majAddci || kind == majAddcui) ? refPsr.c : 1'b0;
				wide = {1'b0, a} + {1'b0, b} + {16'b0, cy};
				res = wide[15:0];
				if (kind == majAddui || kind == majAddcui)
				begin
					mask.c = 1'b1;
					newF.c = wide[16];
				end
				else
				begin
					mask.z = 1'b1;
					mask.f = 1'b1;
					newF.z = (res == 16'h0);
					newF.f = (a[15] == b[15]) && (res[15] != a[15]);
				end
			end
			majSubi:
			begin
				res = a - b;
				mask.z = 1'b1;
				mask.f = 1'b1;
				newF.z = (res == 16'h0);
				newF.f = (a[15] != b[15]) && (res[15] != a[15]);
			end
			majCmpi:
			begin
				wb = 1'b0;
				mask.z = 1'b1;
				mask.n = 1'b1;
				newF.z = (a == b);
				newF.n = $signed(b) > $signed(a);
			end
			majCmpui:
			begin
				wb = 1'b0;
				mask.z = 1'b1;
				mask.l = 1'b1;
				newF.z = (a == b);
				newF.l = b > a;
			end
			majAndi: res = a & b;
			majOri: res = a | b;
			majXori: res = a ^ b;
			majMovi: res = b;
			majLshi: res = (b[4:0] > 5'd15) ? 16'h0 : a << b[4:0];
			majRshi: res = (b[4:0] > 5'd15) ? 16'h0 : a >> b[4:0];
			majArshi:
			begin
				// Sign fill once the amount reaches the word width
				if (b[4:0] > 5'd15)
					res = {16{a[15]}};
				else
					res = $signed(a) >>> b[4:0];
			end
			4'd0: res = ~a;
			default: wb = 1'b0;
		endcase
		if (wb)
			refRegs[rd] = res;
		refPsr = (refPsr & ~mask) | (newF & mask);
	endtask

	task automatic checkReg(input logic [3:0] idx);
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(regAddr(idx), data, resp);
		compareValue($sformatf("r%0d", idx), {16'h0, refRegs[idx]}, data);
		compareValue("rresp", {30'h0, respOkay}, {30'h0, resp});
	endtask

	task automatic checkPsr();
		logic [31:0] data;
		logic [1:0] resp;
		axiRead(psrOffset, data, resp);
		compareValue("psr", {27'h0, refPsr}, data);
		compareValue("rresp", {30'h0, respOkay}, {30'h0, resp});
	endtask

	task automatic checkAllState();
		int i;
		for (i = 0; i < 16; i++)
			checkReg(4'(i));
		checkPsr();
	endtask

	// Run an instruction, then compare Rdest and PSR with the model
	task automatic execCheck(input logic [15:0] w);
		refExec(w);
		axiWrite(instrOffset, {16'h0, w}, 4'hF, respOkay);
		checkReg(w[11:8]);
		checkPsr();
	endtask

	task automatic resetState();
		@(posedge clk);
		compareValue("bvalid", 32'h0, {31'h0, axiRsp.bvalid});
		compareValue("rvalid", 32'h0, {31'h0, axiRsp.rvalid});
		compareValue("awready", 32'h0, {31'h0, axiRsp.awready});
		compareValue("wready", 32'h0, {31'h0, axiRsp.wready});
		compareValue("arready", 32'h0, {31'h0, axiRsp.arready});
		checkAllState();
	endtask

	task automatic addSubOps();
		logic [31:0] rnd;
		dataWord opA;
		dataWord opB;
		int i;
		// Set C, L and N so the loop shows they hold
		loadReg(4'd5, 16'hFFFF);
		loadReg(4'd6, 16'h0001);
		loadReg(4'd7, 16'h0100);
		execCheck(encReg(extAddu, 4'd5, 4'd6));
		execCheck(encReg(extCmpu, 4'd6, 4'd7));
		execCheck(encReg(extCmp, 4'd6, 4'd7));
		for (i = 0; i < 40; i++)
		begin
			rnd = $random(seed);
			opA = rnd[15:0];
			opB = rnd[31:16];
			// A few corners for F and Z
			if (i == 0)
			begin
				opA = 16'h7FFF;
				opB = 16'h0001;
			end
			if (i == 1)
				opB = opA;
			if (i == 2)
			begin
				opA = 16'h8000;
				opB = 16'h8000;
			end
			loadReg(4'd1, opA);
			loadReg(4'd2, opB);
			loadReg(4'd3, opA);
			execCheck(encReg(extAdd, 4'd1, 4'd2));
			execCheck(encReg(extSub, 4'd3, 4'd2));
			// Negative imm8
			execCheck(encImm(majAddi, 4'd2, {1'b1, rnd[6:0]}));
		end
	endtask

	task automatic carryChain();
		logic [31:0] rnd;
		logic [31:0] rnd2;
		logic [31:0] sum32;
		logic [31:0] lo;
		logic [31:0] hi;
		logic [1:0] resp;
		int i;
		for (i = 0; i < 8; i++)
		begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			// Carry out of both halves on the first pass
			if (i == 0)
			begin
				rnd[15:0] = 16'hFFFF;
				rnd2[15:0] = 16'h0001;
				rnd[31:16] = 16'h8000;
				rnd2[31:16] = 16'h8000;
			end
			sum32 = rnd + rnd2;
			loadReg(4'd8, rnd[15:0]);
			loadReg(4'd9, rnd[31:16]);
			loadReg(4'd10, rnd2[15:0]);
			loadReg(4'd11, rnd2[31:16]);
			execCheck(encReg(extAddu, 4'd8, 4'd10));
			execCheck(encReg(extAddcu, 4'd9, 4'd11));
			axiRead(regAddr(4'd8), lo, resp);
			axiRead(regAddr(4'd9), hi, resp);
			compareValue("sum32", sum32, {hi[15:0], lo[15:0]});
			// Carry-in from the PSR for the signed forms
			execCheck(encImm(majAddci, 4'd12, rnd2[7:0]));
			execCheck(encReg(extAddc, 4'd13, 4'd10));
		end
	endtask

	task automatic compareOps();
		logic [31:0] rnd;
		dataWord opA;
		dataWord opB;
		int i;
		for (i = 0; i < 10; i++)
		begin
			rnd = $random(seed);
			opA = rnd[15:0];
			opB = rnd[31:16];
			if (i == 0)
				opB = opA;
			// Signed and unsigned order disagree here
			if (i == 1)
			begin
				opA = 16'h7FFF;
				opB = 16'h8000;
			end
			if (i == 2)
			begin
				opA = 16'h8000;
				opB = 16'h7FFF;
			end
			loadReg(4'd1, opA);
			loadReg(4'd2, opB);
			execCheck(encReg(extCmp, 4'd1, 4'd2));
			execCheck(encReg(extCmpu, 4'd1, 4'd2));
			execCheck(encImm(majCmpi, 4'd1, rnd[7:0]));
			execCheck(encImm(majCmpui, 4'd1, rnd[7:0]));
		end
	endtask

	task automatic logicShiftOps();
		logic [31:0] rnd;
		logic [7:0] amounts [4];
		dataWord val;
		int j;
		int k;
		amounts = '{8'd0, 8'd5, 8'd15, 8'd16};
		// Carry set so a stray flag clear shows up
		loadReg(4'd6, 16'hFFFF);
		execCheck(encImm(majAddui, 4'd6, 8'h01));
		rnd = $random(seed);
		loadReg(4'd1, rnd[15:0]);
		loadReg(4'd2, rnd[31:16]);
		execCheck(encReg(extAnd, 4'd1, 4'd2));
		execCheck(encReg(extOr, 4'd1, 4'd2));
		execCheck(encReg(extXor, 4'd1, 4'd2));
		execCheck(encReg(extNot, 4'd1, 4'd1));
		execCheck(encReg(extLsh, 4'd1, 4'd2));
		execCheck(encReg(extRsh, 4'd1, 4'd2));
		execCheck(encReg(extMov, 4'd1, 4'd2));
		execCheck(encReg(extNop, 4'd1, 4'd2));
		execCheck(encImm(majAndi, 4'd2, 8'h5A));
		execCheck(encImm(majOri, 4'd2, 8'hC3));
		execCheck(encImm(majXori, 4'd2, 8'hFF));
		// Upper byte must come back zero
		execCheck(encImm(majMovi, 4'd4, 8'h9C));
		for (j = 0; j < 2; j++)
		begin
			val = (j == 0) ? 16'h5A3C : 16'hA5C3;
			for (k = 0; k < 4; k++)
			begin
				loadReg(4'd3, val);
				loadReg(4'd4, val);
				loadReg(4'd5, val);
				execCheck(encImm(majLshi, 4'd3, amounts[k]));
				execCheck(encImm(majRshi, 4'd4, amounts[k]));
				execCheck(encImm(majArshi, 4'd5, amounts[k]));
			end
		end
	endtask

	task automatic errorResponses();
		logic [31:0] data;
		logic [1:0] resp;
		logic [7:0] badAddr [3];
		int i;
		badAddr = '{8'h0C, 8'h42, 8'h80};
		// Undefined major code, then undefined extension
		axiWrite(instrOffset, {16'h0, 4'hF, 4'd1, 8'h12}, 4'hF, respSlvErr);
		axiWrite(instrOffset, {16'h0, 4'h0, 4'd1, 4'hF, 4'd2}, 4'hF, respSlvErr);
		axiWrite(8'h08, 32'h0000BEEF, 4'hF, respSlvErr);
		axiWrite(psrOffset, 32'h0000001F, 4'hF, respSlvErr);
		// Strobes missing byte 1 or byte 0
		axiWrite(regAddr(4'd4), 32'h0000BEEF, 4'b0001, respSlvErr);
		axiWrite(instrOffset, {16'h0, encReg(extNot, 4'd1, 4'd1)}, 4'b0010, respSlvErr);
		for (i = 0; i < 3; i++)
		begin
			axiRead(badAddr[i], data, resp);
			compareValue("rdata", 32'h0, data);
			compareValue("rresp", {30'h0, respSlvErr}, {30'h0, resp});
		end
		checkAllState();
	endtask

	task automatic writeBackPressure();
		logic [31:0] rnd;
		int i;
		rnd = $random(seed);
		// First write with the response left pending
		@(posedge clk);
		axiReq.awaddr <= regAddr(4'd12);
		axiReq.wdata <= {16'h0, rnd[15:0]};
		axiReq.wstrb <= 4'hF;
		axiReq.awvalid <= 1'b1;
		axiReq.wvalid <= 1'b1;
		axiReq.bready <= 1'b0;
		do @(posedge clk); while (!(axiRsp.awready && axiRsp.wready));
		refRegs[12] = rnd[15:0];
		// Second write offered right away
		axiReq.awaddr <= regAddr(4'd13);
		axiReq.wdata <= {16'h0, rnd[31:16]};
		for (i = 0; i < 20; i++)
		begin
			@(posedge clk);
			compareValue("bvalid", 32'h1, {31'h0, axiRsp.bvalid});
			compareValue("awready", 32'h0, {31'h0, axiRsp.awready});
			compareValue("wready", 32'h0, {31'h0, axiRsp.wready});
		end
		axiReq.bready <= 1'b1;
		do @(posedge clk); while (!axiRsp.bvalid);
		compareValue("bresp", {30'h0, respOkay}, {30'h0, axiRsp.bresp});
		// Held write now goes through
		do @(posedge clk); while (!(axiRsp.awready && axiRsp.wready));
		axiReq.awvalid <= 1'b0;
		axiReq.wvalid <= 1'b0;
		refRegs[13] = rnd[31:16];
		do @(posedge clk); while (!axiRsp.bvalid);
		compareValue("bresp", {30'h0, respOkay}, {30'h0, axiRsp.bresp});
		checkReg(4'd12);
		checkReg(4'd13);
	endtask

	initial
	begin
		seed = 59927;
		errCount = 0;
		refRegs = '{default: '0};
		refPsr = '0;
		axiReq <= '0;
		rstN <= 1'b0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		resetState();
		addSubOps();
		carryChain();
		compareOps();
		logicShiftOps();
		errorResponses();
		writeBackPressure();
		$display("Run complete with %0d errors", errCount);
		if (errCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== aluCore.f ====
src/isaPkg.sv
src/busPkg.sv
src/alu.sv
src/instrDecode.sv
src/archState.sv
src/axiLiteSlave.sv
src/aluCore.sv
bench/aluCoreTb.sv

// ==== Makefile ====
# Verilator flow for the execute unit and its testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f aluCore.f --top-module aluCoreTb

# Pass only when the run prints the pass line
sim:
	verilator --binary --timing -f aluCore.f --top-module aluCoreTb -o aluCoreSim
	@out="$$(./obj_dir/aluCoreSim)"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
